// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP := tb_accum_cpu
FILELIST := sim.f
OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
PASS_MSG := No errors
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
src/cpu_pkg.sv
src/alu.sv
src/control_unit.sv
src/datapath.sv
src/program_mem.sv
src/data_bus_master.sv
src/accum_cpu.sv
tb/accum_cpu_checker.sv
tb/tb_accum_cpu.sv

// File: src/accum_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module accum_cpu #(
	parameter int DATA_W = 16,
	parameter int PMEM_DEPTH = 64
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          start,
	input  wire                          load_we,
	input  wire [cpu_pkg::INSTR_W-1:0]   load_addr,
	input  wire [cpu_pkg::INSTR_W-1:0]   load_data,
	input  wire [DATA_W-1:0]             wb_dat_r,
	input  wire                          wb_ack,
	output logic                         busy,
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output logic [cpu_pkg::INSTR_W-1:0]  wb_adr,
	output logic [DATA_W-1:0]            wb_dat_w
);
	import cpu_pkg::*;

	logic pmem_rd;
	logic [SEL_W-1:0] sel;
	logic [LOAD_W-1:0] load;
	logic [REG_W-1:0] reg_sel;
	logic [ALU_OP_W-1:0] alu_op;
	logic alu_start;
	logic inc_pc;
	logic inc_ac;
	logic dec_ac;
	logic clr_ac;
	logic mem_rd;
	logic mem_wr;
	logic mem_done;
	logic zero;
	logic [INSTR_W-1:0] ir;
	logic [INSTR_W-1:0] pc;
	logic [INSTR_W-1:0] ar;
	logic [INSTR_W-1:0] pmem_data;
	logic [DATA_W-1:0] ac;
	logic [DATA_W-1:0] dmem_data;

	control_unit u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.ir(ir),
		.zero(zero),
		.mem_done(mem_done),
		.busy(busy),
		.pmem_rd(pmem_rd),
		.sel(sel),
		.load(load),
		.reg_sel(reg_sel),
		.alu_op(alu_op),
		.alu_start(alu_start),
		.inc_pc(inc_pc),
		.inc_ac(inc_ac),
		.dec_ac(dec_ac),
		.clr_ac(clr_ac),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr)
	);

	datapath #(
		.DATA_W(DATA_W)
	) u_dp (
		.clk(clk),
		.rst_n(rst_n),
		.sel(sel),
		.load(load),
		.reg_sel(reg_sel),
		.alu_op(alu_op),
		.alu_start(alu_start),
		.inc_pc(inc_pc),
		.inc_ac(inc_ac),
		.dec_ac(dec_ac),
		.clr_ac(clr_ac),
		.pmem_data(pmem_data),
		.dmem_data(dmem_data),
		.pc(pc),
		.ir(ir),
		.ar(ar),
		.ac(ac),
		.zero(zero)
	);

	program_mem #(
		.PMEM_DEPTH(PMEM_DEPTH)
	) u_pmem (
		.clk(clk),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.rd(pmem_rd),
		.addr(pc),
		.rdata(pmem_data)
	);

	data_bus_master #(
		.DATA_W(DATA_W)
	) u_dbus (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.addr(ar),
		.wdata(ac),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.rdata(dmem_data),
		.mem_done(mem_done),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w)
	);

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu #(
	parameter int DATA_W = 16
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          op_start,
	input  wire [cpu_pkg::ALU_OP_W-1:0]  alu_op,
	input  wire [DATA_W-1:0]             ac,
	input  wire [DATA_W-1:0]             operand,
	output logic [DATA_W-1:0]            result
);
	import cpu_pkg::*;

	// result is held until the next op, the control unit loads it into ac a cycle later.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			result <= '0;
		else if (op_start)
		begin
			case (alu_op)
				ALU_ADD: result <= ac + operand;
				ALU_SUB: result <= ac - operand;
				ALU_MUL: result <= ac * operand; // low half of the product.
				default: result <= result;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          start,
	input  wire [cpu_pkg::INSTR_W-1:0]   ir,
	input  wire                          zero,
	input  wire                          mem_done,
	output logic                         busy,
	output logic                         pmem_rd,
	output logic [cpu_pkg::SEL_W-1:0]    sel,
	output logic [cpu_pkg::LOAD_W-1:0]   load,
	output logic [cpu_pkg::REG_W-1:0]    reg_sel,
	output logic [cpu_pkg::ALU_OP_W-1:0] alu_op,
	output logic                         alu_start,
	output logic                         inc_pc,
	output logic                         inc_ac,
	output logic                         dec_ac,
	output logic                         clr_ac,
	output logic                         mem_rd,
	output logic                         mem_wr
);
	import cpu_pkg::*;

	localparam int ST_W = 4;
	localparam logic [ST_W-1:0] S_IDLE = 4'd0;
	localparam logic [ST_W-1:0] S_FETCH_RD = 4'd1;
	localparam logic [ST_W-1:0] S_FETCH_IR = 4'd2;
	localparam logic [ST_W-1:0] S_DECODE = 4'd3;
	localparam logic [ST_W-1:0] S_EXEC = 4'd4;
	localparam logic [ST_W-1:0] S_ALU_RUN = 4'd5;
	localparam logic [ST_W-1:0] S_ALU_LOAD = 4'd6;
	localparam logic [ST_W-1:0] S_OPND_RD = 4'd7;
	localparam logic [ST_W-1:0] S_ADDR_LD = 4'd8;
	localparam logic [ST_W-1:0] S_MEM_WAIT = 4'd9;
	localparam logic [ST_W-1:0] S_JMP_TEST = 4'd10;
	localparam logic [ST_W-1:0] S_JMP_TAKE = 4'd11;
	localparam logic [ST_W-1:0] S_JMP_SKIP = 4'd12;

	logic [ST_W-1:0] state;
	logic [ST_W-1:0] dec_state;
	logic [OPC_W-1:0] opc;
	logic reg_ok;

	assign opc = ir[INSTR_W-1:REG_W];
	assign reg_sel = ir[REG_W-1:0];
	assign alu_op = (opc == OP_SUB) ? ALU_SUB : (opc == OP_MUL) ? ALU_MUL : ALU_ADD;

	always_comb
	begin
		case (reg_sel)
			REG_A, REG_B, REG_C, REG_SR, REG_CDR, REG_R: reg_ok = 1'b1;
			default: reg_ok = 1'b0;
		endcase
	end

	always_comb
	begin
		case (opc)
			OP_NOP, OP_CLAC, OP_INCAC, OP_DECAC: dec_state = S_EXEC;
			OP_MVR, OP_MVAC: dec_state = reg_ok ? S_EXEC : S_IDLE;
			OP_ADD, OP_SUB, OP_MUL: dec_state = reg_ok ? S_ALU_RUN : S_IDLE;
			OP_LDAC, OP_STAC, OP_JPNZ: dec_state = S_OPND_RD;
			default: dec_state = S_IDLE; // end and unknown opcodes stop the run.
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			busy <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						busy <= 1'b1;
						state <= S_FETCH_RD;
					end
				end
				S_FETCH_RD: state <= S_FETCH_IR;
				S_FETCH_IR: state <= S_DECODE;
				S_DECODE:
				begin
					state <= dec_state;
					if (dec_state == S_IDLE)
						busy <= 1'b0;
				end
				S_ALU_RUN: state <= S_ALU_LOAD;
				S_OPND_RD: state <= (opc == OP_JPNZ) ? S_JMP_TEST : S_ADDR_LD;
				S_ADDR_LD: state <= S_MEM_WAIT;
				S_MEM_WAIT: state <= mem_done ? S_FETCH_RD : S_MEM_WAIT; // stall on the bus.
				S_JMP_TEST: state <= zero ? S_JMP_SKIP : S_JMP_TAKE;
				S_EXEC, S_ALU_LOAD, S_JMP_TAKE, S_JMP_SKIP: state <= S_FETCH_RD;
				default:
				begin
					state <= S_IDLE;
					busy <= 1'b0;
				end
			endcase
		end
	end

	always_comb
	begin
		pmem_rd = 1'b0;
		sel = SEL_NONE;
		load = LD_NONE;
		alu_start = 1'b0;
		inc_pc = 1'b0;
		inc_ac = 1'b0;
		dec_ac = 1'b0;
		clr_ac = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		case (state)
			S_IDLE:
				if (start)
					load = LD_PC; // idle bus is zero, so the pc restarts at 0.
			S_FETCH_RD, S_OPND_RD: pmem_rd = 1'b1;
			S_FETCH_IR:
			begin
				sel = SEL_PMEM;
				load = LD_IR;
				inc_pc = 1'b1;
			end
			S_EXEC:
			begin
				case (opc)
					OP_CLAC: clr_ac = 1'b1;
					OP_INCAC: inc_ac = 1'b1;
					OP_DECAC: dec_ac = 1'b1;
					OP_MVR:
					begin
						sel = SEL_REG;
						load = LD_AC;
					end
					OP_MVAC:
					begin
						sel = SEL_AC;
						load = LD_REG;
					end
					default: ;
				endcase
			end
			S_ALU_RUN:
			begin
				sel = SEL_REG;
				alu_start = 1'b1;
			end
			S_ALU_LOAD:
			begin
				sel = SEL_ALU;
				load = LD_AC;
			end
			S_ADDR_LD:
			begin
				// ar loads on the same edge that opens the bus cycle.
				sel = SEL_PMEM;
				load = LD_AR;
				inc_pc = 1'b1;
				mem_rd = (opc == OP_LDAC);
				mem_wr = (opc == OP_STAC);
			end
			S_MEM_WAIT:
			begin
				if (mem_done && opc == OP_LDAC)
				begin
					sel = SEL_DMEM;
					load = LD_AC;
				end
			end
			S_JMP_TAKE:
			begin
				sel = SEL_PMEM; // target byte still held on the read port.
				load = LD_PC;
			end
			S_JMP_SKIP: inc_pc = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// one instruction byte, also the pc and data address width.
	localparam int INSTR_W = 8;
	localparam int OPC_W = 4;
	localparam int REG_W = 4;

	localparam logic [OPC_W-1:0] OP_NOP = 4'd0;
	localparam logic [OPC_W-1:0] OP_CLAC = 4'd1;
	localparam logic [OPC_W-1:0] OP_LDAC = 4'd2;
	localparam logic [OPC_W-1:0] OP_STAC = 4'd3;
	localparam logic [OPC_W-1:0] OP_MVR = 4'd4;
	localparam logic [OPC_W-1:0] OP_MVAC = 4'd5;
	localparam logic [OPC_W-1:0] OP_MUL = 4'd6;
	localparam logic [OPC_W-1:0] OP_ADD = 4'd7;
	localparam logic [OPC_W-1:0] OP_SUB = 4'd8;
	localparam logic [OPC_W-1:0] OP_JPNZ = 4'd10;
	localparam logic [OPC_W-1:0] OP_INCAC = 4'd11;
	localparam logic [OPC_W-1:0] OP_DECAC = 4'd12;
	localparam logic [OPC_W-1:0] OP_END = 4'd15;

	// register field, low nibble of the instruction.
	localparam logic [REG_W-1:0] REG_A = 4'd1;
	localparam logic [REG_W-1:0] REG_B = 4'd2;
	localparam logic [REG_W-1:0] REG_C = 4'd3;
	localparam logic [REG_W-1:0] REG_SR = 4'd4;
	localparam logic [REG_W-1:0] REG_CDR = 4'd5;
	localparam logic [REG_W-1:0] REG_R = 4'd7;

	localparam int SEL_W = 3;
	localparam logic [SEL_W-1:0] SEL_NONE = 3'd0;
	localparam logic [SEL_W-1:0] SEL_PMEM = 3'd1;
	localparam logic [SEL_W-1:0] SEL_DMEM = 3'd2;
	localparam logic [SEL_W-1:0] SEL_REG = 3'd3;
	localparam logic [SEL_W-1:0] SEL_AC = 3'd4;
	localparam logic [SEL_W-1:0] SEL_ALU = 3'd5;

	localparam int ALU_OP_W = 2;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 2'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 2'd1;
	localparam logic [ALU_OP_W-1:0] ALU_MUL = 2'd2;

	localparam int LOAD_W = 3;
	localparam logic [LOAD_W-1:0] LD_NONE = 3'd0;
	localparam logic [LOAD_W-1:0] LD_IR = 3'd1;
	localparam logic [LOAD_W-1:0] LD_AR = 3'd2;
	localparam logic [LOAD_W-1:0] LD_PC = 3'd3;
	localparam logic [LOAD_W-1:0] LD_AC = 3'd4;
	localparam logic [LOAD_W-1:0] LD_REG = 3'd5;

endpackage

`default_nettype wire

// File: src/data_bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module data_bus_master #(
	parameter int DATA_W = 16
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          mem_rd,
	input  wire                          mem_wr,
	input  wire [cpu_pkg::INSTR_W-1:0]   addr,
	input  wire [DATA_W-1:0]             wdata,
	input  wire [DATA_W-1:0]             wb_dat_r,
	input  wire                          wb_ack,
	output logic [DATA_W-1:0]            rdata,
	output logic                         mem_done,
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output logic [cpu_pkg::INSTR_W-1:0]  wb_adr,
	output logic [DATA_W-1:0]            wb_dat_w
);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			mem_done <= 1'b0;
		end
		else
		begin
			mem_done <= 1'b0;
			if (wb_cyc)
			begin
				if (wb_ack)
				begin
					wb_cyc <= 1'b0;
					wb_stb <= 1'b0;
					wb_we <= 1'b0;
					mem_done <= 1'b1;
				end
			end
			else if (mem_rd || mem_wr)
			begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1; // single transfer per cycle.
				wb_we <= mem_wr;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wb_cyc && wb_ack && !wb_we)
			rdata <= wb_dat_r;
	end

	// ar and ac do not change while the control unit waits for done.
	assign wb_adr = addr;
	assign wb_dat_w = wdata;

endmodule

`default_nettype wire

// File: src/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath #(
	parameter int DATA_W = 16
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire [cpu_pkg::SEL_W-1:0]     sel,
	input  wire [cpu_pkg::LOAD_W-1:0]    load,
	input  wire [cpu_pkg::REG_W-1:0]     reg_sel,
	input  wire [cpu_pkg::ALU_OP_W-1:0]  alu_op,
	input  wire                          alu_start,
	input  wire                          inc_pc,
	input  wire                          inc_ac,
	input  wire                          dec_ac,
	input  wire                          clr_ac,
	input  wire [cpu_pkg::INSTR_W-1:0]   pmem_data,
	input  wire [DATA_W-1:0]             dmem_data,
	output logic [cpu_pkg::INSTR_W-1:0]  pc,
	output logic [cpu_pkg::INSTR_W-1:0]  ir,
	output logic [cpu_pkg::INSTR_W-1:0]  ar,
	output logic [DATA_W-1:0]            ac,
	output logic                         zero
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] bus;
	logic [DATA_W-1:0] reg_q;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] reg_a;
	logic [DATA_W-1:0] reg_b;
	logic [DATA_W-1:0] reg_c;
	logic [DATA_W-1:0] reg_sr;
	logic [DATA_W-1:0] reg_cdr;
	logic [DATA_W-1:0] reg_r;

	alu #(
		.DATA_W(DATA_W)
	) u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.op_start(alu_start),
		.alu_op(alu_op),
		.ac(ac),
		.operand(bus),
		.result(alu_result)
	);

	always_comb
	begin
		case (sel)
			SEL_PMEM: bus = {{(DATA_W-INSTR_W){1'b0}}, pmem_data};
			SEL_DMEM: bus = dmem_data;
			SEL_REG: bus = reg_q;
			SEL_AC: bus = ac;
			SEL_ALU: bus = alu_result;
			default: bus = '0;
		endcase
	end

	always_comb
	begin
		case (reg_sel)
			REG_A: reg_q = reg_a;
			REG_B: reg_q = reg_b;
			REG_C: reg_q = reg_c;
			REG_SR: reg_q = reg_sr;
			REG_CDR: reg_q = reg_cdr;
			REG_R: reg_q = reg_r;
			default: reg_q = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= '0;
			ir <= '0;
			ar <= '0;
			ac <= '0;
		end
		else
		begin
			if (load == LD_PC)
				pc <= bus[INSTR_W-1:0];
			else if (inc_pc)
				pc <= pc + 1'b1;
			if (load == LD_IR)
				ir <= bus[INSTR_W-1:0];
			if (load == LD_AR)
				ar <= bus[INSTR_W-1:0];
			if (clr_ac)
				ac <= '0;
			else if (load == LD_AC)
				ac <= bus;
			else if (inc_ac)
				ac <= ac + 1'b1; // wraps.
			else if (dec_ac)
				ac <= ac - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load == LD_REG)
		begin
			case (reg_sel)
				REG_A: reg_a <= bus;
				REG_B: reg_b <= bus;
				REG_C: reg_c <= bus;
				REG_SR: reg_sr <= bus;
				REG_CDR: reg_cdr <= bus;
				REG_R: reg_r <= bus;
				default: ;
			endcase
		end
	end

	assign zero = (ac == '0);

endmodule

`default_nettype wire

// File: src/program_mem.sv
`timescale 1ns/100ps
`default_nettype none

module program_mem #(
	parameter int PMEM_DEPTH = 64
) (
	input  wire                          clk,
	input  wire                          load_we,
	input  wire [cpu_pkg::INSTR_W-1:0]   load_addr,
	input  wire [cpu_pkg::INSTR_W-1:0]   load_data,
	input  wire                          rd,
	input  wire [cpu_pkg::INSTR_W-1:0]   addr,
	output logic [cpu_pkg::INSTR_W-1:0]  rdata
);
	import cpu_pkg::*;

	localparam int AW = (PMEM_DEPTH > 1) ? $clog2(PMEM_DEPTH) : 1;

	logic [INSTR_W-1:0] mem [PMEM_DEPTH];

	always_ff @(posedge clk)
	begin
		if (load_we && (load_addr < PMEM_DEPTH))
			mem[load_addr[AW-1:0]] <= load_data;
	end

	always_ff @(posedge clk)
	begin
		if (rd)
		begin
			if (addr < PMEM_DEPTH)
				rdata <= mem[addr[AW-1:0]];
			else
				rdata <= {OP_END, {REG_W{1'b0}}}; // running off the end halts.
		end
	end

endmodule

`default_nettype wire

// File: tb/accum_cpu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module accum_cpu_checker #(
	parameter int DATA_W = 16
) (
	input wire                        clk,
	input wire                        rst_n,
	input wire                        busy,
	input wire                        wb_cyc,
	input wire                        wb_stb,
	input wire                        wb_we,
	input wire                        wb_ack,
	input wire [cpu_pkg::INSTR_W-1:0] wb_adr,
	input wire [DATA_W-1:0]           wb_dat_w
);

	int unsigned fail_count = 0; // read by the testbench at the end.

	stb_held: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb)
	else
	begin
		fail_count++;
		$error("wb_stb dropped before wb_ack");
	end

	cyc_is_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc == wb_stb)
	else
	begin
		fail_count++;
		$error("wb_cyc and wb_stb differ");
	end

	// master must hold the request while the slave stalls.
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_we))
	else
	begin
		fail_count++;
		$error("address, data or we changed while waiting for wb_ack");
	end

	idle_after_reset: assert property (@(posedge clk) !rst_n |=> !busy)
	else
	begin
		fail_count++;
		$error("busy high in the cycle after reset");
	end

endmodule

bind accum_cpu accum_cpu_checker #(
	.DATA_W(DATA_W)
) u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.busy(busy),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_ack(wb_ack),
	.wb_adr(wb_adr),
	.wb_dat_w(wb_dat_w)
);

`default_nettype wire

// File: tb/tb_accum_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_accum_cpu;
	import cpu_pkg::*;

	localparam int DATA_W = 16;
	localparam int PMEM_DEPTH = 64;
	localparam int TIMEOUT = 2000;
	localparam time DRIVE_DLY = 1;

	logic clk;
	logic rst_n;
	logic start;
	logic load_we;
	logic [INSTR_W-1:0] load_addr;
	logic [INSTR_W-1:0] load_data;
	logic [DATA_W-1:0] wb_dat_r;
	logic wb_ack;
	logic busy;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [INSTR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_dat_w;

	logic [31:0] lcg_state = 32'hc5ff_9cbc;
	int errors;
	bit aborted;
	bit rand_waits;

	logic [INSTR_W-1:0] prog [PMEM_DEPTH];
	int prog_len;
	logic [DATA_W-1:0] bus_mem [256];
	logic [DATA_W-1:0] model_regs [16];
	logic [DATA_W-1:0] model_ac;
	logic [INSTR_W-1:0] exp_adr [$];
	logic [DATA_W-1:0] exp_dat [$];
	logic [INSTR_W-1:0] act_adr [$];
	logic [DATA_W-1:0] act_dat [$];
	logic [INSTR_W-1:0] ref_adr [$];
	logic [DATA_W-1:0] ref_dat [$];

	accum_cpu #(
		.DATA_W(DATA_W),
		.PMEM_DEPTH(PMEM_DEPTH)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.busy(busy),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// wishbone slave with 0 to 3 wait states per transfer.
	initial
	begin : wb_slave
		int wait_left;
		bit in_cycle;
		wb_ack = 1'b0;
		wb_dat_r = '0;
		in_cycle = 1'b0;
		wait_left = 0;
		forever
		begin
			@(posedge clk);
			#DRIVE_DLY;
			wb_ack = 1'b0;
			if (wb_cyc && wb_stb)
			begin
				if (!in_cycle)
				begin
					in_cycle = 1'b1;
					wait_left = rand_waits ? int'((lcg_next() >> 16) % 4) : 0;
				end
				if (wait_left == 0)
				begin
					wb_ack = 1'b1;
					in_cycle = 1'b0;
					if (wb_we)
					begin
						bus_mem[wb_adr] = wb_dat_w;
						act_adr.push_back(wb_adr);
						act_dat.push_back(wb_dat_w);
					end
					else
						wb_dat_r = bus_mem[wb_adr];
				end
				else
					wait_left--;
			end
		end
	end

	task automatic fill_data_mem();
		for (int a = 0; a < 256; a++)
			bus_mem[a] = DATA_W'(lcg_next() >> 8);
	endtask

	task automatic clear_program();
		prog_len = 0;
		for (int i = 0; i < PMEM_DEPTH; i++)
			prog[i] = {OP_END, 4'h0};
	endtask

	task automatic emit_instr(input logic [OPC_W-1:0] opc, input logic [REG_W-1:0] fld);
		prog[prog_len] = {opc, fld};
		prog_len++;
	endtask

	task automatic append_byte(input logic [INSTR_W-1:0] b);
		prog[prog_len] = b;
		prog_len++;
	endtask

	function automatic logic [INSTR_W-1:0] fetch_byte(input logic [INSTR_W-1:0] pc);
		return (pc < PMEM_DEPTH) ? prog[pc] : {OP_END, 4'h0};
	endfunction

	// instruction level model, builds the expected write list.
	task automatic predict_program();
		logic [INSTR_W-1:0] pc;
		logic [INSTR_W-1:0] ins;
		logic [INSTR_W-1:0] opnd;
		logic [REG_W-1:0] rf;
		logic [DATA_W-1:0] mem [256];
		bit reg_valid;
		bit running;
		int steps;
		pc = '0;
		running = 1'b1;
		steps = 0;
		exp_adr.delete();
		exp_dat.delete();
		for (int i = 0; i < 256; i++)
			mem[i] = bus_mem[i];
		while (running && steps < 10000)
		begin
			ins = fetch_byte(pc);
			pc = pc + 1'b1;
			rf = ins[REG_W-1:0];
			reg_valid = rf inside {REG_A, REG_B, REG_C, REG_SR, REG_CDR, REG_R};
			steps++;
			case (ins[INSTR_W-1:REG_W])
				OP_NOP: ;
				OP_CLAC: model_ac = '0;
				OP_INCAC: model_ac = model_ac + 1'b1;
				OP_DECAC: model_ac = model_ac - 1'b1;
				OP_LDAC, OP_STAC:
				begin
					opnd = fetch_byte(pc);
					pc = pc + 1'b1;
					if (ins[INSTR_W-1:REG_W] == OP_LDAC)
						model_ac = mem[opnd];
					else
					begin
						mem[opnd] = model_ac;
						exp_adr.push_back(opnd);
						exp_dat.push_back(model_ac);
					end
				end
				OP_JPNZ:
				begin
					opnd = fetch_byte(pc);
					pc = (model_ac != '0) ? opnd : pc + 1'b1;
				end
				OP_MVR, OP_MVAC, OP_ADD, OP_SUB, OP_MUL:
				begin
					if (!reg_valid)
						running = 1'b0; // bad register code halts.
					else if (ins[INSTR_W-1:REG_W] == OP_MVR)
						model_ac = model_regs[rf];
					else if (ins[INSTR_W-1:REG_W] == OP_MVAC)
						model_regs[rf] = model_ac;
					else if (ins[INSTR_W-1:REG_W] == OP_ADD)
						model_ac = model_ac + model_regs[rf];
					else if (ins[INSTR_W-1:REG_W] == OP_SUB)
						model_ac = model_ac - model_regs[rf];
					else
						model_ac = model_ac * model_regs[rf];
				end
				default: running = 1'b0;
			endcase
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < PMEM_DEPTH; i++)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			load_we = 1'b1;
			load_addr = INSTR_W'(i);
			load_data = prog[i];
		end
		@(posedge clk);
		#DRIVE_DLY;
		load_we = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (busy !== level && cycles < TIMEOUT)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			cycles++;
		end
		if (busy !== level)
		begin
			$display("timeout: busy did not %s within %0d cycles", what, TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	task automatic compare_logs(input string name, input bit to_model);
		int n;
		int exp_n;
		exp_n = to_model ? exp_adr.size() : ref_adr.size();
		n = (exp_n < act_adr.size()) ? exp_n : act_adr.size();
		assert (act_adr.size() == exp_n) else
		begin
			errors++;
			$display("[FAIL] %s write count: expected %0d, actual %0d", name, exp_n,
				act_adr.size());
		end
		for (int i = 0; i < n; i++)
		begin
			assert (act_adr[i] == (to_model ? exp_adr[i] : ref_adr[i])) else
			begin
				errors++;
				$display("[FAIL] %s write %0d address: expected %h, actual %h", name, i,
					to_model ? exp_adr[i] : ref_adr[i], act_adr[i]);
			end
			assert (act_dat[i] == (to_model ? exp_dat[i] : ref_dat[i])) else
			begin
				errors++;
				$display("[FAIL] %s write %0d data: expected %h, actual %h", name, i,
					to_model ? exp_dat[i] : ref_dat[i], act_dat[i]);
			end
		end
	endtask

	task automatic run_program(input string name);
		if (!aborted)
		begin
			predict_program();
			load_program();
			act_adr.delete();
			act_dat.delete();
			@(posedge clk);
			#DRIVE_DLY;
			start = 1'b1;
			wait_busy(1'b1, "rise after start");
			start = 1'b0;
			if (!aborted)
				wait_busy(1'b0, "fall at the end of the program");
			if (!aborted)
			begin
				compare_logs(name, 1'b1);
				assert (UUT.u_dp.ac == model_ac) else
				begin
					errors++;
					$display("[FAIL] %s final ac: expected %h, actual %h", name, model_ac,
						UUT.u_dp.ac);
				end
				assert (!wb_cyc) else
				begin
					errors++;
					$display("%s left a bus cycle open after busy fell", name);
				end
			end
		end
	endtask

	initial
	begin : main
		logic [DATA_W-1:0] count;
		start = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		rst_n = 1'b0;
		errors = 0;
		aborted = 1'b0;
		rand_waits = 1'b0;
		model_ac = '0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		fill_data_mem();
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		// nothing may happen before start.
		repeat (6)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			assert (!busy && !wb_cyc) else
			begin
				errors++;
				$display("busy or a bus cycle seen while idle before start");
			end
		end
		clear_program();
		emit_instr(OP_NOP, 4'h0);
		emit_instr(OP_INCAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h30);
		emit_instr(OP_END, 4'h0);
		run_program("reset_idle");

		clear_program();
		for (int r = 0; r < 6; r++)
		begin
			emit_instr(OP_LDAC, 4'h0);
			append_byte(INSTR_W'(r));
			emit_instr(OP_MVAC, (r == 5) ? REG_R : REG_W'(r + 1));
		end
		emit_instr(OP_MVR, REG_A);
		emit_instr(OP_ADD, REG_B);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h40);
		emit_instr(OP_SUB, REG_C);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h41);
		emit_instr(OP_MUL, REG_SR);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h42);
		emit_instr(OP_MVAC, REG_C); // round trip through c.
		emit_instr(OP_MVR, REG_CDR);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h43);
		emit_instr(OP_MVR, REG_C);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h44);
		emit_instr(OP_ADD, REG_R);
		emit_instr(OP_MUL, REG_CDR);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h45);
		emit_instr(OP_MVR, REG_R);
		emit_instr(OP_SUB, REG_A);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h46);
		emit_instr(OP_NOP, 4'h0);
		emit_instr(OP_END, 4'h0);
		run_program("arith_no_wait");
		ref_adr = act_adr;
		ref_dat = act_dat;

		// same program again, now with random stalls.
		rand_waits = 1'b1;
		run_program("arith_backpressure");
		if (!aborted)
			compare_logs("backpressure_vs_no_wait", 1'b0);

		bus_mem[8'h07] = '1;
		clear_program();
		emit_instr(OP_CLAC, 4'h0);
		emit_instr(OP_DECAC, 4'h0); // wraps to all ones.
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h50);
		emit_instr(OP_INCAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h51);
		emit_instr(OP_DECAC, 4'h0);
		emit_instr(OP_DECAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h52);
		emit_instr(OP_LDAC, 4'h0);
		append_byte(8'h06);
		emit_instr(OP_INCAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h53);
		emit_instr(OP_DECAC, 4'h0);
		emit_instr(OP_DECAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h54);
		emit_instr(OP_LDAC, 4'h0);
		append_byte(8'h07);
		emit_instr(OP_INCAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h56);
		emit_instr(OP_CLAC, 4'h0);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h55);
		emit_instr(OP_END, 4'h0);
		run_program("inc_dec_clear");

		count = DATA_W'((lcg_next() >> 16) % 8 + 1);
		bus_mem[8'h10] = count;
		clear_program();
		emit_instr(OP_LDAC, 4'h0);
		append_byte(8'h10);
		emit_instr(OP_STAC, 4'h0); // loop body at address 2.
		append_byte(8'h20);
		emit_instr(OP_DECAC, 4'h0);
		emit_instr(OP_JPNZ, 4'h0);
		append_byte(8'h02);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h21);
		emit_instr(OP_END, 4'h0);
		run_program("jpnz_loop");

		clear_program();
		emit_instr(OP_LDAC, 4'h0);
		append_byte(8'h08);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h60);
		emit_instr(OP_MVAC, 4'h6);
		emit_instr(OP_STAC, 4'h0);
		append_byte(8'h61);
		emit_instr(OP_END, 4'h0);
		run_program("bad_register");

		$display("closing counts: %0d check errors, %0d assertion failures, %0d timeouts",
			errors, UUT.u_chk.fail_count, aborted);
		if (errors == 0 && UUT.u_chk.fail_count == 0 && !aborted)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
